//--- rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`define REG_COUNT 32

// Longest wait for a memory resp before the core counts as hung
`define MEM_WAIT_MAX 16

`endif

//--- rtl/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0] reg_idx;

    // Only the opcodes this core executes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // addi x0, x0, 0
    localparam rv32i_word nop_instr = 32'h0000_0013;

endpackage

//--- rtl/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    // alu_add must stay at zero so an all-zero word is a bubble
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_ops;

    typedef enum logic [1:0] {
        i_imm_sel,
        s_imm_sel,
        rs2_sel
    } alumux2_sel_t;

    typedef enum logic [1:0] {
        alu_out_wb_sel,
        u_imm_wb_sel,
        rdata_wb_sel
    } wbmux_sel_t;

    typedef struct packed {
        alu_ops aluop;
        alumux2_sel_t alumux2_sel;
        wbmux_sel_t wbmux_sel;
        logic load_regfile;
        logic dmem_read;
        logic dmem_write;
        logic [2:0] funct3;
    } rv32i_control_word;

endpackage

//--- rtl/control_rom.sv
`timescale 1ns/1ps

module control_rom import rv32i_types::*, pipe_ctrl_pkg::*; (
    input rv32i_word instr,
    output rv32i_control_word ctw,
    output reg_idx rs1,
    output reg_idx rs2,
    output reg_idx rd
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic valid;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];

    always_comb begin
        ctw = '0;
        ctw.funct3 = funct3;
        ctw.load_regfile = 1'b1;
        valid = 1'b1;
        case (rv32i_opcode'(instr[6:0]))
            op_reg: begin
                ctw.alumux2_sel = rs2_sel;
                // funct7 bit 5 only selects sub and sra
                valid = (funct7 == 7'h00) ||
                        (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
                case (funct3)
                    3'b000: ctw.aluop = funct7[5] ? alu_sub : alu_add;
                    3'b001: ctw.aluop = alu_sll;
                    3'b010: ctw.aluop = alu_slt;
                    3'b011: ctw.aluop = alu_sltu;
                    3'b100: ctw.aluop = alu_xor;
                    3'b101: ctw.aluop = funct7[5] ? alu_sra : alu_srl;
                    3'b110: ctw.aluop = alu_or;
                    default: ctw.aluop = alu_and;
                endcase
            end
            op_imm: begin
                ctw.alumux2_sel = i_imm_sel;
                case (funct3)
                    3'b000: ctw.aluop = alu_add;
                    3'b010: ctw.aluop = alu_slt;
                    3'b100: ctw.aluop = alu_xor;
                    3'b110: ctw.aluop = alu_or;
                    3'b111: ctw.aluop = alu_and;
                    default: valid = 1'b0;
                endcase
            end
            op_lui: ctw.wbmux_sel = u_imm_wb_sel;
            op_load: begin
                ctw.wbmux_sel = rdata_wb_sel;
                ctw.dmem_read = 1'b1;
                valid = funct3 inside {lb, lh, lw, lbu, lhu};
            end
            op_store: begin
                ctw.alumux2_sel = s_imm_sel;
                ctw.load_regfile = 1'b0;
                ctw.dmem_write = 1'b1;
                valid = funct3 inside {sb, sh, sw};
            end
            default: valid = 1'b0;
        endcase
        if (!valid) begin
            ctw = '0;
        end
    end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regfile import rv32i_types::*; (
    input logic clk,
    input logic rst_n,
    input logic load,
    input reg_idx rd,
    input reg_idx rs1,
    input reg_idx rs2,
    input rv32i_word in,
    output rv32i_word rs1_out,
    output rv32i_word rs2_out
);

    rv32i_word data [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                data[i] <= '0;
            end
        end else if (load && rd != '0) begin
            data[rd] <= in;
        end
    end

    assign rs1_out = data[rs1];
    assign rs2_out = data[rs2];

    x0_rs1_zero: assert property (@(posedge clk) disable iff (!rst_n)
        rs1 == '0 |-> rs1_out == '0);
    x0_rs2_zero: assert property (@(posedge clk) disable iff (!rst_n)
        rs2 == '0 |-> rs2_out == '0);

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import rv32i_types::*, pipe_ctrl_pkg::*; (
    input alu_ops aluop,
    input rv32i_word a,
    input rv32i_word b,
    output rv32i_word f
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            alu_add: f = a + b;
            alu_sub: f = a - b;
            alu_sll: f = a << shamt;
            alu_slt: f = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'd0, a < b};
            alu_xor: f = a ^ b;
            alu_srl: f = a >> shamt;
            alu_sra: f = rv32i_word'($signed(a) >>> shamt);
            alu_or: f = a | b;
            default: f = a & b;
        endcase
    end

endmodule

//--- rtl/hazard_forward_unit.sv
`timescale 1ns/1ps

module hazard_forward_unit import rv32i_types::*; (
    input reg_idx rs1,
    input reg_idx rs2,
    input reg_idx rs1_ex,
    input reg_idx rs2_ex,
    input reg_idx rd_ex,
    input reg_idx rd_mem,
    input reg_idx rd_wb,
    input logic load_ex,
    input logic load_regfile_mem,
    input logic load_regfile_wb,
    output logic stall,
    output logic rs1_id_sel,
    output logic rs2_id_sel,
    output logic [1:0] rs1_ex_sel,
    output logic [1:0] rs2_ex_sel
);

    logic mem_writes, wb_writes;

    // x0 is never a forwarding source
    assign mem_writes = load_regfile_mem && rd_mem != '0;
    assign wb_writes = load_regfile_wb && rd_wb != '0;

    // Load in execute with a consumer in decode
    assign stall = load_ex && rd_ex != '0 && (rd_ex == rs1 || rd_ex == rs2);

    // Same-cycle register file write seen by decode
    assign rs1_id_sel = wb_writes && rd_wb == rs1;
    assign rs2_id_sel = wb_writes && rd_wb == rs2;

    // 0 keeps the ID/EX value, 1 takes memory stage, 2 takes write-back
    always_comb begin
        rs1_ex_sel = 2'd0;
        if (mem_writes && rd_mem == rs1_ex) begin
            rs1_ex_sel = 2'd1;
        end else if (wb_writes && rd_wb == rs1_ex) begin
            rs1_ex_sel = 2'd2;
        end
        rs2_ex_sel = 2'd0;
        if (mem_writes && rd_mem == rs2_ex) begin
            rs2_ex_sel = 2'd1;
        end else if (wb_writes && rd_wb == rs2_ex) begin
            rs2_ex_sel = 2'd2;
        end
    end

endmodule

//--- rtl/mem_align.sv
`timescale 1ns/1ps

module mem_align import rv32i_types::*; (
    input logic clk,
    input logic rst_n,
    input logic dmem_write,
    input rv32i_word mem_addr,
    input logic [2:0] mem_funct3,
    input rv32i_word store_data,
    input rv32i_word dmem_rdata,
    output logic [3:0] dmem_byte_enable,
    output rv32i_word dmem_wdata,
    output rv32i_word load_data
);

    logic [1:0] offset;
    logic [7:0] rbyte;
    logic [15:0] rhalf;

    assign offset = mem_addr[1:0];
    assign rbyte = dmem_rdata[{offset, 3'b000} +: 8];
    assign rhalf = dmem_rdata[{offset[1], 4'b0000} +: 16];

    always_comb begin
        dmem_byte_enable = 4'h0;
        dmem_wdata = '0;
        case (store_funct3_t'(mem_funct3))
            sb: begin
                dmem_byte_enable = 4'b0001 << offset;
                dmem_wdata = {24'd0, store_data[7:0]} << {offset, 3'b000};
            end
            sh: begin
                // Odd halfword address leaves enables at zero
                if (!offset[0]) begin
                    dmem_byte_enable = 4'b0011 << offset;
                    dmem_wdata = {16'd0, store_data[15:0]} << {offset, 3'b000};
                end
            end
            sw: begin
                dmem_byte_enable = 4'hf;
                dmem_wdata = store_data;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (load_funct3_t'(mem_funct3))
            lb: load_data = {{24{rbyte[7]}}, rbyte};
            lh: load_data = {{16{rhalf[15]}}, rhalf};
            lbu: load_data = {24'd0, rbyte};
            lhu: load_data = {16'd0, rhalf};
            default: load_data = dmem_rdata;
        endcase
    end

    no_empty_write: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_write |-> dmem_byte_enable != 4'h0);

endmodule

//--- rtl/cpu_datapath.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_datapath import rv32i_types::*, pipe_ctrl_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic imem_resp,
    input rv32i_word imem_rdata,
    input logic dmem_resp,
    input rv32i_word load_data,
    output logic imem_read,
    output rv32i_word imem_address,
    output logic dmem_read,
    output logic dmem_write,
    output rv32i_word mem_addr,
    output logic [2:0] mem_funct3,
    output rv32i_word store_data
);

    rv32i_word pc, fetched, imem_buf, load_buf;
    rv32i_word ir_id, ir_ex;
    logic imem_done, dmem_done, imem_busy, dmem_busy, busy, stall, fetch_adv;
    rv32i_control_word ctw_id, ctw_ex, ctw_mem, ctw_wb;
    reg_idx rs1_id, rs2_id, rd_id, rs1_ex, rs2_ex, rd_ex, rd_mem, rd_wb;
    logic rs1_id_sel, rs2_id_sel;
    logic [1:0] rs1_ex_sel, rs2_ex_sel;
    rv32i_word rs1_rf, rs2_rf, rs1_id_val, rs2_id_val, rs1_ex_val, rs2_ex_val;
    rv32i_word rs1_fwd, rs2_fwd, i_imm, s_imm, u_imm, alu_b, alu_out, ex_result;
    rv32i_word result_mem, rs2_mem, result_wb, load_wb, wb_data;

    // A completed request is remembered so a frozen stage never asks twice
    assign imem_read = ~imem_done;
    assign imem_address = pc;
    assign dmem_read = ctw_mem.dmem_read & ~dmem_done;
    assign dmem_write = ctw_mem.dmem_write & ~dmem_done;

    assign imem_busy = imem_read & ~imem_resp;
    assign dmem_busy = (dmem_read | dmem_write) & ~dmem_resp;
    assign busy = imem_busy | dmem_busy;
    assign fetch_adv = ~busy & ~stall;
    assign fetched = imem_done ? imem_buf : imem_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
            ir_id <= nop_instr;
            imem_done <= 1'b0;
        end else if (fetch_adv) begin
            pc <= pc + 32'd4;
            ir_id <= fetched;
            imem_done <= 1'b0;
        end else if (imem_read && imem_resp) begin
            imem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_done <= 1'b0;
        end else if (!busy) begin
            dmem_done <= 1'b0;
        end else if ((dmem_read || dmem_write) && dmem_resp) begin
            dmem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_read && imem_resp) begin
            imem_buf <= imem_rdata;
        end
        if (dmem_resp) begin
            load_buf <= load_data;
        end
    end

    control_rom control (
        .instr(ir_id),
        .ctw(ctw_id),
        .rs1(rs1_id),
        .rs2(rs2_id),
        .rd(rd_id)
    );

    regfile regfile (
        .clk,
        .rst_n,
        .load(ctw_wb.load_regfile),
        .rd(rd_wb),
        .rs1(rs1_id),
        .rs2(rs2_id),
        .in(wb_data),
        .rs1_out(rs1_rf),
        .rs2_out(rs2_rf)
    );

    hazard_forward_unit hfu (
        .rs1(rs1_id),
        .rs2(rs2_id),
        .rs1_ex,
        .rs2_ex,
        .rd_ex,
        .rd_mem,
        .rd_wb,
        .load_ex(ctw_ex.dmem_read),
        .load_regfile_mem(ctw_mem.load_regfile),
        .load_regfile_wb(ctw_wb.load_regfile),
        .stall,
        .rs1_id_sel,
        .rs2_id_sel,
        .rs1_ex_sel,
        .rs2_ex_sel
    );

    assign rs1_id_val = rs1_id_sel ? wb_data : rs1_rf;
    assign rs2_id_val = rs2_id_sel ? wb_data : rs2_rf;

    assign i_imm = {{21{ir_ex[31]}}, ir_ex[30:20]};
    assign s_imm = {{21{ir_ex[31]}}, ir_ex[30:25], ir_ex[11:7]};
    assign u_imm = {ir_ex[31:12], 12'h000};

    always_comb begin
        case (rs1_ex_sel)
            2'd1: rs1_fwd = result_mem;
            2'd2: rs1_fwd = wb_data;
            default: rs1_fwd = rs1_ex_val;
        endcase
        case (rs2_ex_sel)
            2'd1: rs2_fwd = result_mem;
            2'd2: rs2_fwd = wb_data;
            default: rs2_fwd = rs2_ex_val;
        endcase
        case (ctw_ex.alumux2_sel)
            s_imm_sel: alu_b = s_imm;
            rs2_sel: alu_b = rs2_fwd;
            default: alu_b = i_imm;
        endcase
    end

    alu alu (
        .aluop(ctw_ex.aluop),
        .a(rs1_fwd),
        .b(alu_b),
        .f(alu_out)
    );

    // lui resolves here so the memory stage can forward it
    assign ex_result = (ctw_ex.wbmux_sel == u_imm_wb_sel) ? u_imm : alu_out;

    assign mem_addr = result_mem;
    assign mem_funct3 = ctw_mem.funct3;
    assign store_data = rs2_mem;

    assign wb_data = (ctw_wb.wbmux_sel == rdata_wb_sel) ? load_wb : result_wb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctw_ex <= '0;
            ctw_mem <= '0;
            ctw_wb <= '0;
        end else if (!busy) begin
            if (stall) begin
                ctw_ex <= '0;
            end else begin
                ctw_ex <= ctw_id;
            end
            ctw_mem <= ctw_ex;
            ctw_wb <= ctw_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            ir_ex <= ir_id;
            rs1_ex <= rs1_id;
            rs2_ex <= rs2_id;
            rd_ex <= rd_id;
            rs1_ex_val <= rs1_id_val;
            rs2_ex_val <= rs2_id_val;
            result_mem <= ex_result;
            rs2_mem <= rs2_fwd;
            rd_mem <= rd_ex;
            result_wb <= result_mem;
            load_wb <= dmem_done ? load_buf : load_data;
            rd_wb <= rd_mem;
        end
    end

    imem_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_read && !imem_resp |=> $stable(imem_address));

    // A frozen pipeline must thaw once the memories answer
    mem_wait_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> ##[1:`MEM_WAIT_MAX] !busy);

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import rv32i_types::*; (
    input logic clk,
    input logic rst_n,
    input logic imem_resp,
    input rv32i_word imem_rdata,
    input logic dmem_resp,
    input rv32i_word dmem_rdata,
    output logic imem_read,
    output rv32i_word imem_address,
    output logic dmem_read,
    output logic dmem_write,
    output rv32i_word dmem_address,
    output logic [3:0] dmem_byte_enable,
    output rv32i_word dmem_wdata
);

    rv32i_word mem_addr, store_data, load_data;
    logic [2:0] mem_funct3;

    cpu_datapath datapath (
        .clk,
        .rst_n,
        .imem_resp,
        .imem_rdata,
        .dmem_resp,
        .load_data,
        .imem_read,
        .imem_address,
        .dmem_read,
        .dmem_write,
        .mem_addr,
        .mem_funct3,
        .store_data
    );

    // Memory sees word addresses, lanes come from the byte enables
    assign dmem_address = {mem_addr[31:2], 2'b00};

    mem_align align (
        .clk,
        .rst_n,
        .dmem_write,
        .mem_addr,
        .mem_funct3,
        .store_data,
        .dmem_rdata,
        .dmem_byte_enable,
        .dmem_wdata,
        .load_data
    );

endmodule

//--- sim/cpu_top_tb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top_tb import rv32i_types::*; ;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [6:0] f7_base = 7'h00;
    localparam logic [6:0] f7_alt = 7'h20;

    logic clk = 1'b0;
    logic rst_n;
    logic imem_resp;
    rv32i_word imem_rdata;
    logic dmem_resp;
    rv32i_word dmem_rdata;
    logic imem_read;
    rv32i_word imem_address;
    logic dmem_read;
    logic dmem_write;
    rv32i_word dmem_address;
    logic [3:0] dmem_byte_enable;
    rv32i_word dmem_wdata;

    rv32i_word prog [256];
    int prog_len;
    rv32i_word dmem [1024];
    rv32i_word ref_mem [1024];
    int ilat [512];
    int dlat [512];
    int ilat_idx = 0;
    int dlat_idx = 0;
    int iwait = -1;
    int dwait = -1;
    bit hold_mem = 1'b1;
    bit zero_latency = 1'b1;

    rv32i_word exp_addr [$];
    logic [3:0] exp_be [$];
    rv32i_word exp_data [$];
    rv32i_word obs_addr [$];
    logic [3:0] obs_be [$];
    rv32i_word obs_data [$];

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    // Grows by 40 cycles per instruction as each program is loaded
    int cycle_limit = 200;

    cpu_top cpu_top_inst (
        .clk,
        .rst_n,
        .imem_resp,
        .imem_rdata,
        .dmem_resp,
        .dmem_rdata,
        .imem_read,
        .imem_address,
        .dmem_read,
        .dmem_write,
        .dmem_address,
        .dmem_byte_enable,
        .dmem_wdata
    );

    always #10 clk = ~clk;

    function automatic rv32i_word r_op(input logic [6:0] f7, input logic [2:0] f3,
                                       input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic rv32i_word i_op(input logic [2:0] f3, input int rd, input int rs1,
                                       input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
    endfunction

    function automatic rv32i_word load_op(input logic [2:0] f3, input int rd, input int rs1,
                                          input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0000011};
    endfunction

    function automatic rv32i_word store_op(input logic [2:0] f3, input int rs2, input int rs1,
                                           input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_word lui_op(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    task automatic emit(input rv32i_word instr);
        prog[prog_len] = instr;
        prog_len++;
    endtask

    function automatic rv32i_word fetch_word(input rv32i_word addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < prog_len) begin
            return prog[idx];
        end
        return nop_instr;
    endfunction

    // Every word differs, and the pattern uses all address bits
    function automatic rv32i_word fill_word(input rv32i_word addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic rv32i_word lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic int next_latency(input bit data_port);
        int lat;
        if (zero_latency) begin
            return 0;
        end
        if (data_port) begin
            lat = dlat[dlat_idx];
            dlat_idx = (dlat_idx + 1) % 512;
        end else begin
            lat = ilat[ilat_idx];
            ilat_idx = (ilat_idx + 1) % 512;
        end
        return lat;
    endfunction

    // Instruction memory answers one request per resp pulse
    always begin : imem_model
        @(posedge clk);
        #2;
        imem_resp = 1'b0;
        if (!rst_n || hold_mem) begin
            iwait = -1;
        end else if (imem_read) begin
            if (iwait < 0) begin
                iwait = next_latency(1'b0);
            end
            if (iwait == 0) begin
                imem_resp = 1'b1;
                imem_rdata = fetch_word(imem_address);
                iwait = -1;
            end else begin
                iwait--;
            end
        end
    end

    always begin : dmem_model
        int k;
        int idx;
        @(posedge clk);
        #2;
        dmem_resp = 1'b0;
        idx = int'(dmem_address[11:2]);
        if (!rst_n || hold_mem) begin
            dwait = -1;
        end else if (dmem_read || dmem_write) begin
            if (dwait < 0) begin
                dwait = next_latency(1'b1);
            end
            if (dwait == 0) begin
                dmem_resp = 1'b1;
                dwait = -1;
                if (dmem_write) begin
                    obs_addr.push_back(dmem_address);
                    obs_be.push_back(dmem_byte_enable);
                    obs_data.push_back(dmem_wdata);
                    for (k = 0; k < 4; k++) begin
                        if (dmem_byte_enable[k]) begin
                            dmem[idx][8 * k +: 8] = dmem_wdata[8 * k +: 8];
                        end
                    end
                end else begin
                    dmem_rdata = dmem[idx];
                end
            end else begin
                dwait--;
            end
        end
    end

    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles with tests unfinished", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic init_memories();
        int i;
        for (i = 0; i < 1024; i++) begin
            dmem[i] = fill_word(i * 4);
            ref_mem[i] = dmem[i];
        end
    endtask

    // Executes the program in order and lists the stores it must make
    task automatic run_reference();
        rv32i_word regs [32];
        rv32i_word instr, a, b, imm, addr, val, word, data;
        logic [3:0] be;
        logic [7:0] lane8;
        logic [15:0] half16;
        logic write;
        int i, k;
        exp_addr.delete();
        exp_be.delete();
        exp_data.delete();
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < prog_len; i++) begin
            instr = prog[i];
            a = regs[instr[19:15]];
            b = regs[instr[24:20]];
            imm = {{20{instr[31]}}, instr[31:20]};
            write = 1'b1;
            val = '0;
            case (instr[6:0])
                7'b0110111: val = {instr[31:12], 12'h000};
                7'b0010011: begin
                    case (instr[14:12])
                        f3_add: val = a + imm;
                        f3_slt: val = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                        f3_xor: val = a ^ imm;
                        f3_or: val = a | imm;
                        default: val = a & imm;
                    endcase
                end
                7'b0110011: begin
                    case (instr[14:12])
                        f3_add: val = instr[30] ? a - b : a + b;
                        f3_sll: val = a << b[4:0];
                        f3_slt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        f3_sltu: val = (a < b) ? 32'd1 : 32'd0;
                        f3_xor: val = a ^ b;
                        f3_srl: val = instr[30] ? rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
                        f3_or: val = a | b;
                        default: val = a & b;
                    endcase
                end
                7'b0000011: begin
                    addr = a + imm;
                    word = ref_mem[addr[11:2]];
                    lane8 = word[8 * addr[1:0] +: 8];
                    half16 = word[16 * addr[1] +: 16];
                    case (instr[14:12])
                        3'b000: val = {{24{lane8[7]}}, lane8};
                        3'b001: val = {{16{half16[15]}}, half16};
                        3'b100: val = {24'h0, lane8};
                        3'b101: val = {16'h0, half16};
                        default: val = word;
                    endcase
                end
                7'b0100011: begin
                    write = 1'b0;
                    addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    case (instr[14:12])
                        3'b000: begin
                            be = 4'b0001 << addr[1:0];
                            data = {4{b[7:0]}};
                        end
                        3'b001: begin
                            be = 4'b0011 << addr[1:0];
                            data = {2{b[15:0]}};
                        end
                        default: begin
                            be = 4'b1111;
                            data = b;
                        end
                    endcase
                    for (k = 0; k < 4; k++) begin
                        if (be[k]) begin
                            ref_mem[addr[11:2]][8 * k +: 8] = data[8 * k +: 8];
                        end
                    end
                    exp_addr.push_back({addr[31:2], 2'b00});
                    exp_be.push_back(be);
                    exp_data.push_back(data);
                end
                default: write = 1'b0;
            endcase
            if (write && instr[11:7] != 5'd0) begin
                regs[instr[11:7]] = val;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        obs_addr.delete();
        obs_be.delete();
        obs_data.delete();
        rst_n = 1'b1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic run_program(input string name, input bit fixed_latency);
        int errors_before, i, n;
        rv32i_word mask;
        errors_before = errors;
        zero_latency = fixed_latency;
        init_memories();
        run_reference();
        cycle_limit += 40 * prog_len;
        hold_mem = 1'b0;
        apply_reset();
        while (obs_addr.size() < exp_addr.size()) begin
            @(posedge clk);
        end
        // Quiet window so a repeated store would still show up
        repeat (20) @(posedge clk);
        assert (obs_addr.size() == exp_addr.size()) else begin
            $display("%s saw %0d stores where %0d were expected", name, obs_addr.size(),
                     exp_addr.size());
            errors++;
        end
        n = (obs_addr.size() < exp_addr.size()) ? obs_addr.size() : exp_addr.size();
        for (i = 0; i < n; i++) begin
            mask = lane_mask(exp_be[i]);
            assert (obs_addr[i] == exp_addr[i]) else begin
                $display("error: dmem_address store %0d got %h expected %h", i, obs_addr[i],
                         exp_addr[i]);
                errors++;
            end
            assert (obs_be[i] == exp_be[i]) else begin
                $display("error: dmem_byte_enable store %0d got %h expected %h", i, obs_be[i],
                         exp_be[i]);
                errors++;
            end
            assert ((obs_data[i] & mask) == (exp_data[i] & mask)) else begin
                $display("error: dmem_wdata store %0d got %h expected %h", i,
                         obs_data[i] & mask, exp_data[i] & mask);
                errors++;
            end
        end
        report_test(name, errors_before);
    endtask

    task automatic check_reset();
        int errors_before, i;
        errors_before = errors;
        hold_mem = 1'b1;
        prog_len = 0;
        apply_reset();
        @(negedge clk);
        assert (imem_read) else begin
            $display("imem_read was not raised in the first cycle after reset");
            errors++;
        end
        assert (imem_address == `RESET_PC) else begin
            $display("error: imem_address got %h expected %h", imem_address, `RESET_PC);
            errors++;
        end
        for (i = 0; i < 10; i++) begin
            assert (!dmem_read) else begin
                $display("error: dmem_read got %h expected %h", dmem_read, 1'b0);
                errors++;
            end
            assert (!dmem_write) else begin
                $display("error: dmem_write got %h expected %h", dmem_write, 1'b0);
                errors++;
            end
            @(negedge clk);
        end
        report_test("reset", errors_before);
    endtask

    // Dependent chain with producers right before their consumers
    task automatic build_alu_program();
        int r;
        prog_len = 0;
        emit(lui_op(1, 'h12345));
        emit(i_op(f3_add, 1, 1, 'h678));
        emit(i_op(f3_add, 2, 0, -5));
        emit(r_op(f7_base, f3_add, 3, 1, 2));
        emit(r_op(f7_alt, f3_add, 4, 3, 1));
        emit(r_op(f7_base, f3_xor, 5, 4, 1));
        emit(r_op(f7_base, f3_or, 6, 5, 2));
        emit(r_op(f7_base, f3_and, 7, 6, 1));
        emit(r_op(f7_base, f3_slt, 8, 2, 1));
        emit(r_op(f7_base, f3_sltu, 9, 2, 1));
        emit(i_op(f3_add, 10, 0, 4));
        emit(r_op(f7_base, f3_sll, 11, 1, 10));
        emit(r_op(f7_base, f3_srl, 12, 2, 10));
        emit(r_op(f7_alt, f3_srl, 13, 2, 10));
        emit(i_op(f3_and, 14, 1, 'h0f0));
        emit(i_op(f3_or, 15, 2, 'h100));
        emit(i_op(f3_xor, 16, 1, -1));
        emit(i_op(f3_slt, 17, 2, -4));
        emit(lui_op(18, 'hfedcb));
        emit(i_op(f3_add, 20, 0, 'h200));
        for (r = 3; r <= 18; r++) begin
            emit(store_op(sw, r, 20, 4 * (r - 3)));
        end
        emit(r_op(f7_base, f3_add, 19, 11, 12));
        emit(store_op(sw, 19, 20, 64));
    endtask

    task automatic check_alu_chain();
        build_alu_program();
        run_program("alu_chain", 1'b1);
    endtask

    task automatic check_load_use();
        prog_len = 0;
        emit(i_op(f3_add, 20, 0, 'h300));
        emit(i_op(f3_add, 1, 0, 'h123));
        emit(store_op(sw, 1, 20, 0));
        emit(load_op(lw, 2, 20, 0));
        emit(r_op(f7_base, f3_add, 3, 2, 1));
        emit(store_op(sw, 3, 20, 4));
        emit(load_op(lw, 4, 20, 8));
        emit(r_op(f7_base, f3_add, 5, 4, 4));
        emit(store_op(sw, 5, 20, 12));
        emit(load_op(lw, 6, 20, 8));
        emit(store_op(sw, 6, 20, 16));
        run_program("load_use", 1'b1);
    endtask

    task automatic check_subword_stores();
        int r;
        prog_len = 0;
        emit(lui_op(1, 'h89abc));
        emit(i_op(f3_add, 1, 1, 'h5ef));
        emit(i_op(f3_add, 20, 0, 'h400));
        for (r = 0; r < 4; r++) begin
            emit(store_op(sb, 1, 20, r));
        end
        emit(store_op(sh, 1, 20, 4));
        emit(store_op(sh, 1, 20, 6));
        run_program("subword_stores", 1'b1);
    endtask

    task automatic check_subword_loads();
        int r;
        prog_len = 0;
        emit(i_op(f3_add, 20, 0, 'h500));
        // Every byte of 0x8c9ad7b8 has its top bit set
        emit(lui_op(1, 'h8c9ad));
        emit(i_op(f3_add, 1, 1, 'h7b8));
        emit(store_op(sw, 1, 20, 0));
        emit(load_op(lb, 2, 20, 0));
        emit(load_op(lb, 3, 20, 3));
        emit(load_op(lbu, 4, 20, 1));
        emit(load_op(lbu, 5, 20, 2));
        emit(load_op(lh, 6, 20, 0));
        emit(load_op(lh, 7, 20, 2));
        emit(load_op(lhu, 8, 20, 0));
        emit(load_op(lhu, 9, 20, 2));
        for (r = 2; r <= 9; r++) begin
            emit(store_op(sw, r, 20, 4 * (r - 1)));
        end
        run_program("subword_loads", 1'b1);
    endtask

    task automatic check_back_pressure();
        build_alu_program();
        run_program("back_pressure", 1'b0);
    endtask

    initial begin
        int i;
        rst_n = 1'b0;
        imem_resp = 1'b0;
        imem_rdata = nop_instr;
        dmem_resp = 1'b0;
        dmem_rdata = '0;
        prog_len = 0;
        void'($urandom(32'h476ad0b3));
        for (i = 0; i < 512; i++) begin
            ilat[i] = $urandom % 4;
            dlat[i] = $urandom % 4;
        end
        check_reset();
        check_alu_chain();
        check_load_use();
        check_subword_stores();
        check_subword_loads();
        check_back_pressure();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- cpu_top.f
+incdir+rtl
rtl/rv32i_types.sv
rtl/pipe_ctrl_pkg.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/alu.sv
rtl/hazard_forward_unit.sv
rtl/mem_align.sv
rtl/cpu_datapath.sv
rtl/cpu_top.sv
sim/cpu_top_tb.sv
